// ==== buffer_manager.f ====
+incdir+design
design/buffer_manager_pkg.sv
design/dpram.sv
design/fm_pingpong.sv
design/filter_loader.sv
design/buffer_manager.sv
bench/buffer_manager_assertions.sv
bench/tb_buffer_manager.sv

// ==== Bender.yml ====
package:
  name: buffer_manager

sources:
  - include_dirs:
      - design
    files:
      - design/buffer_manager_pkg.sv
      - design/dpram.sv
      - design/fm_pingpong.sv
      - design/filter_loader.sv
      - design/buffer_manager.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/buffer_manager_assertions.sv
      - bench/tb_buffer_manager.sv

// ==== bench/tb_buffer_manager.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "buffer_manager_cfg.svh"

module tb_buffer_manager;

    localparam int TIMEOUT = 2000;
    localparam int N_IFM   = 64;
    localparam int N_OFM   = 16;
    localparam int N_WORDS = 8;     // channel 2 x 4

    logic                             clk;
    logic                             rstn;
    logic                             fm_switch;
    logic                             load_ifm;
    logic                             load_filter;
    logic                             axi_vld;
    buffer_manager_pkg::fm_data_t     axi_data;
    logic                             ofm_vld;
    buffer_manager_pkg::fm_addr_t     ofm_addr;
    buffer_manager_pkg::fm_data_t     ofm_data;
    buffer_manager_pkg::size_t        width;
    buffer_manager_pkg::size_t        height;
    buffer_manager_pkg::chan_t        channel;
    buffer_manager_pkg::chan_t        channel_out;
    logic                             maxpool;
    logic [1:0]                       maxpool_stride;
    logic                             upsample;
    logic                             tap_vld;
    buffer_manager_pkg::fm_addr_t     tap_addr;
    buffer_manager_pkg::fm_data_t     tap_data;
    logic                             ofm_sync_done;
    logic                             filter_ready;
    logic                             fb_req;
    buffer_manager_pkg::filter_addr_t fb_addr;
    buffer_manager_pkg::filter_word_t fb_data0;
    buffer_manager_pkg::filter_word_t fb_data1;
    buffer_manager_pkg::filter_word_t fb_data2;
    buffer_manager_pkg::filter_word_t fb_data3;

    logic [15:0]                      lfsr;
    buffer_manager_pkg::fm_data_t     ifm_model [N_IFM];
    buffer_manager_pkg::fm_data_t     ofm_model [N_OFM];
    buffer_manager_pkg::filter_word_t fb_model [N_WORDS][`BM_FILTER_BANKS];

    buffer_manager u_buffer_manager (
        .clk            (clk),
        .rstn           (rstn),
        .fm_switch      (fm_switch),
        .load_ifm       (load_ifm),
        .load_filter    (load_filter),
        .axi_vld        (axi_vld),
        .axi_data       (axi_data),
        .ofm_vld        (ofm_vld),
        .ofm_addr       (ofm_addr),
        .ofm_data       (ofm_data),
        .width          (width),
        .height         (height),
        .channel        (channel),
        .channel_out    (channel_out),
        .maxpool        (maxpool),
        .maxpool_stride (maxpool_stride),
        .upsample       (upsample),
        .tap_vld        (tap_vld),
        .tap_addr       (tap_addr),
        .tap_data       (tap_data),
        .ofm_sync_done  (ofm_sync_done),
        .filter_ready   (filter_ready),
        .fb_req         (fb_req),
        .fb_addr        (fb_addr),
        .fb_data0       (fb_data0),
        .fb_data1       (fb_data1),
        .fb_data2       (fb_data2),
        .fb_data3       (fb_data3)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------
    // random source, 16 bit galois lfsr
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_fm(input string name, input buffer_manager_pkg::fm_data_t got,
                            input buffer_manager_pkg::fm_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_filter(input string name, input buffer_manager_pkg::filter_word_t got,
                                input buffer_manager_pkg::filter_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // bus helpers
    task automatic send_beat(input buffer_manager_pkg::fm_data_t d);
        int gap;
        gap = rand_bits(2);
        repeat (gap) begin
            @(posedge clk);
            axi_vld <= 1'b0;
        end
        @(posedge clk);
        axi_vld  <= 1'b1;
        axi_data <= d;
    endtask

    task automatic tap_read(input int a, output buffer_manager_pkg::fm_data_t d);
        @(posedge clk);
        tap_vld  <= 1'b1;
        tap_addr <= buffer_manager_pkg::fm_addr_t'(a);
        @(posedge clk);
        tap_vld <= 1'b0;
        @(negedge clk);
        d = tap_data;       // one cycle after the read
    endtask

    task automatic wait_filter_ready;
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout: filter_ready never rose after the filter load");
            end
        end while (filter_ready !== 1'b1);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    task automatic load_ifm_words(input int n);
        @(posedge clk);
        load_ifm <= 1'b1;
        for (int i = 0; i < n; i++) begin
            ifm_model[i] = rand_bits(32);
            send_beat(ifm_model[i]);
        end
        @(posedge clk);
        axi_vld <= 1'b0;
        @(posedge clk);
        load_ifm <= 1'b0;
    endtask

    task automatic check_ifm_words;
        buffer_manager_pkg::fm_data_t got;
        for (int i = 0; i < N_IFM; i++) begin
            tap_read(i, got);
            check_fm($sformatf("tap_data at %0d", i), got, ifm_model[i]);
        end
    endtask

    task automatic check_pingpong;
        buffer_manager_pkg::fm_data_t got;
        for (int i = 0; i < N_OFM; i++) begin
            ofm_model[i] = rand_bits(32);
            @(posedge clk);
            ofm_vld  <= 1'b1;
            ofm_addr <= buffer_manager_pkg::fm_addr_t'(i);
            ofm_data <= ofm_model[i];
        end
        @(posedge clk);
        ofm_vld   <= 1'b0;
        fm_switch <= 1'b1;  // buffer 1 becomes ifm
        @(posedge clk);
        fm_switch <= 1'b0;
        for (int i = 0; i < N_OFM; i++) begin
            tap_read(i, got);
            check_fm($sformatf("tap_data at %0d after switch", i), got, ofm_model[i]);
        end
        @(posedge clk);
        fm_switch <= 1'b1;
        @(posedge clk);
        fm_switch <= 1'b0;
        check_ifm_words();
    endtask

    task automatic check_ofm_done(input int w, input int h, input int c, input logic mp,
                                  input logic [1:0] st, input logic up, input int last);
        @(posedge clk);
        width          <= buffer_manager_pkg::size_t'(w);
        height         <= buffer_manager_pkg::size_t'(h);
        channel_out    <= buffer_manager_pkg::chan_t'(c);
        maxpool        <= mp;
        maxpool_stride <= st;
        upsample       <= up;
        for (int a = 0; a <= last + 3; a++) begin
            @(posedge clk);
            ofm_vld  <= 1'b1;
            ofm_addr <= buffer_manager_pkg::fm_addr_t'(a);
            ofm_data <= rand_bits(32);
            @(negedge clk);
            check_bit($sformatf("ofm_sync_done at %0d", a), ofm_sync_done, a == last);
        end
        @(posedge clk);
        ofm_vld <= 1'b0;
    endtask

    task automatic load_filters(input int chan);
        int n_beats;
        int w;
        int p;
        logic [31:0] d;
        n_beats = chan * 4 * `BM_KERNEL_TAPS;
        @(posedge clk);
        channel     <= buffer_manager_pkg::chan_t'(chan);
        load_filter <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("filter_ready after load edge", filter_ready, 1'b0);
        for (int b = 0; b < n_beats; b++) begin
            w = b / `BM_KERNEL_TAPS;
            p = b % `BM_KERNEL_TAPS;
            d = rand_bits(32);
            for (int k = 0; k < `BM_FILTER_BANKS; k++) begin
                fb_model[w][k][8*p +: 8] = d[8*k +: 8];   // byte k to bank k
            end
            if (b == n_beats - 1) begin
                @(negedge clk);
                check_bit("filter_ready before last beat", filter_ready, 1'b0);
            end
            send_beat(d);
        end
        @(posedge clk);
        axi_vld <= 1'b0;
        wait_filter_ready();
        @(posedge clk);
        load_filter <= 1'b0;
    endtask

    task automatic check_filter_words;
        for (int a = 0; a < N_WORDS; a++) begin
            @(posedge clk);
            fb_req  <= 1'b1;
            fb_addr <= buffer_manager_pkg::filter_addr_t'(a);
            @(posedge clk);
            fb_req <= 1'b0;
            @(negedge clk);
            check_filter($sformatf("fb_data0 at %0d", a), fb_data0, fb_model[a][0]);
            check_filter($sformatf("fb_data1 at %0d", a), fb_data1, fb_model[a][1]);
            check_filter($sformatf("fb_data2 at %0d", a), fb_data2, fb_model[a][2]);
            check_filter($sformatf("fb_data3 at %0d", a), fb_data3, fb_model[a][3]);
        end
    endtask

    // ------------------------------------------------------------------
    initial begin
        lfsr           = 16'd8;
        clk            = 1'b0;
        rstn           = 1'b0;
        fm_switch      = 1'b0;
        load_ifm       = 1'b0;
        load_filter    = 1'b0;
        axi_vld        = 1'b0;
        axi_data       = '0;
        ofm_vld        = 1'b0;
        ofm_addr       = '0;
        ofm_data       = '0;
        width          = '0;
        height         = '0;
        channel        = '0;
        channel_out    = '0;
        maxpool        = 1'b0;
        maxpool_stride = 2'd0;
        upsample       = 1'b0;
        tap_vld        = 1'b0;
        tap_addr       = '0;
        fb_req         = 1'b0;
        fb_addr        = '0;

        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_bit("ofm_sync_done after reset", ofm_sync_done, 1'b0);
        check_bit("filter_ready after reset", filter_ready, 1'b0);

        load_ifm_words(N_IFM);
        check_ifm_words();
        load_ifm_words(8);      // second load restarts at address 0
        check_ifm_words();

        check_pingpong();

        // last address = eff_w x eff_h x channel_out - 1, geometry 6 x 4 x 3
        check_ofm_done(6, 4, 3, 1'b0, 2'd0, 1'b0, 71);
        check_ofm_done(6, 4, 3, 1'b1, 2'd2, 1'b0, 17);
        check_ofm_done(6, 4, 3, 1'b1, 2'd1, 1'b0, 71);
        check_ofm_done(6, 4, 3, 1'b0, 2'd0, 1'b1, 287);

        load_filters(2);
        check_filter_words();
        @(negedge clk);
        check_bit("filter_ready held after load", filter_ready, 1'b1);
        load_filters(1);        // words 4..7 keep the first load
        check_filter_words();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/buffer_manager_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module buffer_manager_assertions (
    input wire                               clk,
    input wire                               rstn,
    input wire                               ofm_vld,
    input wire                               ofm_sync_done,
    input wire                               bank_we,
    input wire                               filter_ready,
    input wire                               tap_vld,
    input wire buffer_manager_pkg::fm_data_t tap_data
);

    // completion only flagged on an ofm write
    sync_done_needs_vld: assert property (
        @(posedge clk) disable iff (!rstn) ofm_sync_done |-> ofm_vld
    ) else $error("ofm_sync_done high without ofm_vld");

    ready_after_write: assert property (
        @(posedge clk) disable iff (!rstn) $rose(filter_ready) |-> $past(bank_we)
    ) else $error("filter_ready rose without a bank write the cycle before");

    tap_data_known: assert property (
        @(posedge clk) disable iff (!rstn) tap_vld |=> !$isunknown(tap_data)
    ) else $error("tap_data unknown one cycle after tap_vld");

endmodule

// bank_we is internal to the top level
bind buffer_manager buffer_manager_assertions u_buffer_manager_assertions (
    .clk           (clk),
    .rstn          (rstn),
    .ofm_vld       (ofm_vld),
    .ofm_sync_done (ofm_sync_done),
    .bank_we       (bank_we),
    .filter_ready  (filter_ready),
    .tap_vld       (tap_vld),
    .tap_data      (tap_data)
);

`default_nettype wire

// ==== design/buffer_manager.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "buffer_manager_cfg.svh"

module buffer_manager (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 fm_switch,
    input  wire                                 load_ifm,
    input  wire                                 load_filter,
    input  wire                                 axi_vld,
    input  wire buffer_manager_pkg::fm_data_t   axi_data,
    input  wire                                 ofm_vld,
    input  wire buffer_manager_pkg::fm_addr_t   ofm_addr,
    input  wire buffer_manager_pkg::fm_data_t   ofm_data,
    input  wire buffer_manager_pkg::size_t      width,
    input  wire buffer_manager_pkg::size_t      height,
    input  wire buffer_manager_pkg::chan_t      channel,
    input  wire buffer_manager_pkg::chan_t      channel_out,
    input  wire                                 maxpool,
    input  wire [1:0]                           maxpool_stride,
    input  wire                                 upsample,
    input  wire                                 tap_vld,
    input  wire buffer_manager_pkg::fm_addr_t   tap_addr,
    output buffer_manager_pkg::fm_data_t        tap_data,
    output logic                                ofm_sync_done,
    output logic                                filter_ready,
    input  wire                                 fb_req,
    input  wire buffer_manager_pkg::filter_addr_t fb_addr,
    output buffer_manager_pkg::filter_word_t    fb_data0,
    output buffer_manager_pkg::filter_word_t    fb_data1,
    output buffer_manager_pkg::filter_word_t    fb_data2,
    output buffer_manager_pkg::filter_word_t    fb_data3
);

    logic                             bank_we;
    buffer_manager_pkg::filter_addr_t bank_addr;
    buffer_manager_pkg::filter_word_t bank_wdata [`BM_FILTER_BANKS];
    buffer_manager_pkg::filter_word_t bank_rdata [`BM_FILTER_BANKS];

    // ------------------------------------------------------------------
    // feature maps
    fm_pingpong u_fm_pingpong (
        .clk            (clk),
        .rstn           (rstn),
        .fm_switch      (fm_switch),
        .load_ifm       (load_ifm),
        .axi_vld        (axi_vld),
        .axi_data       (axi_data),
        .ofm_vld        (ofm_vld),
        .ofm_addr       (ofm_addr),
        .ofm_data       (ofm_data),
        .width          (width),
        .height         (height),
        .channel_out    (channel_out),
        .maxpool        (maxpool),
        .maxpool_stride (maxpool_stride),
        .upsample       (upsample),
        .tap_vld        (tap_vld),
        .tap_addr       (tap_addr),
        .tap_data       (tap_data),
        .ofm_sync_done  (ofm_sync_done)
    );

    // ------------------------------------------------------------------
    // filters, same axi stream as the ifm load
    filter_loader u_filter_loader (
        .clk          (clk),
        .rstn         (rstn),
        .load_filter  (load_filter),
        .axi_vld      (axi_vld),
        .axi_data     (axi_data),
        .channel      (channel),
        .bank_we      (bank_we),
        .bank_addr    (bank_addr),
        .bank_wdata0  (bank_wdata[0]),
        .bank_wdata1  (bank_wdata[1]),
        .bank_wdata2  (bank_wdata[2]),
        .bank_wdata3  (bank_wdata[3]),
        .filter_ready (filter_ready)
    );

    for (genvar b = 0; b < `BM_FILTER_BANKS; b++) begin : g_bank
        dpram #(
            .DEPTH (`BM_FILTER_DEPTH),
            .AW    (`BM_FILTER_AW),
            .DW    (`BM_FILTER_DW)
        ) u_filter_bank (
            .clk   (clk),
            .we    (bank_we),
            .waddr (bank_addr),
            .wdata (bank_wdata[b]),
            .re    (fb_req),
            .raddr (fb_addr),        // shared read address
            .rdata (bank_rdata[b])
        );
    end

    assign fb_data0 = bank_rdata[0];
    assign fb_data1 = bank_rdata[1];
    assign fb_data2 = bank_rdata[2];
    assign fb_data3 = bank_rdata[3];

endmodule

`default_nettype wire

// ==== design/filter_loader.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "buffer_manager_cfg.svh"

module filter_loader (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               load_filter,
    input  wire                               axi_vld,
    input  wire buffer_manager_pkg::fm_data_t axi_data,
    input  wire buffer_manager_pkg::chan_t    channel,
    output logic                              bank_we,
    output buffer_manager_pkg::filter_addr_t  bank_addr,
    output buffer_manager_pkg::filter_word_t  bank_wdata0,
    output buffer_manager_pkg::filter_word_t  bank_wdata1,
    output buffer_manager_pkg::filter_word_t  bank_wdata2,
    output buffer_manager_pkg::filter_word_t  bank_wdata3,
    output logic                              filter_ready
);

    localparam buffer_manager_pkg::tap_idx_t LAST_TAP = `BM_KERNEL_TAPS - 1;

    buffer_manager_pkg::filter_state_e state;
    buffer_manager_pkg::tap_idx_t      tap;
    buffer_manager_pkg::tap_idx_t      tap_use;
    buffer_manager_pkg::filter_word_t  acc [`BM_FILTER_BANKS];
    buffer_manager_pkg::filter_addr_t  last_addr;

    logic load_filter_d;
    logic load_edge;
    logic beat_vld;
    logic start;
    logic commit;

    assign load_edge = load_filter & ~load_filter_d;
    assign beat_vld  = load_filter && axi_vld &&
                       (load_edge || state != buffer_manager_pkg::FL_IDLE);
    assign start     = beat_vld && (load_edge || state == buffer_manager_pkg::FL_ARMED);
    assign tap_use   = start ? '0 : tap;                 // first beat is always tap 0
    assign commit    = beat_vld && (tap_use == LAST_TAP);
    assign last_addr = buffer_manager_pkg::filter_addr_t'(channel * `BM_FILTER_BANKS - 1);

    // ------------------------------------------------------------------
    // load state, tap counter, write address
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_filter_d <= 1'b0;
            state         <= buffer_manager_pkg::FL_IDLE;
            tap           <= '0;
            bank_we       <= 1'b0;
            bank_addr     <= '0;
            filter_ready  <= 1'b0;
        end else begin
            load_filter_d <= load_filter;

            if (!load_filter) begin
                state <= buffer_manager_pkg::FL_IDLE;
            end else if (start) begin
                state <= buffer_manager_pkg::FL_PACKING;
            end else if (load_edge) begin
                state <= buffer_manager_pkg::FL_ARMED;
            end

            if (beat_vld) begin
                tap <= (tap_use == LAST_TAP) ? '0 : tap_use + 1'b1;
            end

            bank_we <= commit;   // write lands one cycle after the 9th beat
            if (start) begin
                bank_addr <= '0;
            end else if (bank_we) begin
                bank_addr <= (bank_addr == last_addr) ? '0 : bank_addr + 1'b1;
            end

            // ready after the last word of channel x 4
            if (load_edge) begin
                filter_ready <= 1'b0;
            end else if (bank_we && bank_addr == last_addr) begin
                filter_ready <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // byte k of each beat to bank k, tap p to bits 8p+7:8p
    always_ff @(posedge clk) begin
        if (beat_vld) begin
            for (int k = 0; k < `BM_FILTER_BANKS; k++) begin
                acc[k][8*tap_use +: 8] <= axi_data[8*k +: 8];
            end
        end
    end

    assign bank_wdata0 = acc[0];
    assign bank_wdata1 = acc[1];
    assign bank_wdata2 = acc[2];
    assign bank_wdata3 = acc[3];

endmodule

`default_nettype wire

// ==== design/fm_pingpong.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "buffer_manager_cfg.svh"

module fm_pingpong (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          fm_switch,
    input  wire                          load_ifm,
    input  wire                          axi_vld,
    input  wire buffer_manager_pkg::fm_data_t axi_data,
    input  wire                          ofm_vld,
    input  wire buffer_manager_pkg::fm_addr_t ofm_addr,
    input  wire buffer_manager_pkg::fm_data_t ofm_data,
    input  wire buffer_manager_pkg::size_t    width,
    input  wire buffer_manager_pkg::size_t    height,
    input  wire buffer_manager_pkg::chan_t    channel_out,
    input  wire                          maxpool,
    input  wire [1:0]                    maxpool_stride,
    input  wire                          upsample,
    input  wire                          tap_vld,
    input  wire buffer_manager_pkg::fm_addr_t tap_addr,
    output buffer_manager_pkg::fm_data_t      tap_data,
    output logic                         ofm_sync_done
);

    buffer_manager_pkg::fm_role_e buf0_role;
    buffer_manager_pkg::fm_role_e buf1_role;

    logic                         load_ifm_d;
    logic                         load_start;
    logic                         app_we;
    buffer_manager_pkg::fm_addr_t app_addr;
    buffer_manager_pkg::fm_data_t app_data;

    logic                         buf0_we, buf1_we;
    logic                         buf0_re, buf1_re;
    buffer_manager_pkg::fm_addr_t buf0_waddr;
    buffer_manager_pkg::fm_data_t buf0_wdata;
    buffer_manager_pkg::fm_data_t buf0_rdata, buf1_rdata;
    logic                         tap_from_buf1;

    logic [`BM_W_SIZE:0]          eff_w, eff_h;     // one bit more for 2x upsample
    buffer_manager_pkg::fm_addr_t ofm_last_addr;

    // ------------------------------------------------------------------
    // role pointers swap on every layer switch
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf0_role <= buffer_manager_pkg::ROLE_IFM;
            buf1_role <= buffer_manager_pkg::ROLE_OFM;
        end else if (fm_switch) begin
            buf0_role <= buf1_role;
            buf1_role <= buf0_role;
        end
    end

    // ------------------------------------------------------------------
    // axi append writer into buffer 0
    assign load_start = load_ifm & ~load_ifm_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_ifm_d <= 1'b0;
            app_we     <= 1'b0;
            app_addr   <= '0;
        end else begin
            load_ifm_d <= load_ifm;
            app_we     <= load_ifm & axi_vld;
            if (load_start) begin
                app_addr <= '0;                 // every load restarts at 0
            end else if (app_we) begin
                app_addr <= app_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        app_data <= axi_data;
    end

    // ofm writes to buffer 0 are dropped while a load owns it
    assign buf0_we    = load_ifm_d ? app_we
                                   : (ofm_vld && buf0_role == buffer_manager_pkg::ROLE_OFM);
    assign buf0_waddr = load_ifm_d ? app_addr : ofm_addr;
    assign buf0_wdata = load_ifm_d ? app_data : ofm_data;
    assign buf1_we    = ofm_vld && (buf1_role == buffer_manager_pkg::ROLE_OFM);

    // ------------------------------------------------------------------
    // tap read of whichever buffer is ifm
    assign buf0_re = tap_vld && (buf0_role == buffer_manager_pkg::ROLE_IFM);
    assign buf1_re = tap_vld && (buf1_role == buffer_manager_pkg::ROLE_IFM);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_from_buf1 <= 1'b0;
        end else if (tap_vld) begin
            tap_from_buf1 <= (buf1_role == buffer_manager_pkg::ROLE_IFM);
        end
    end

    assign tap_data = tap_from_buf1 ? buf1_rdata : buf0_rdata;

    dpram #(.DEPTH(`BM_FM_DEPTH), .AW(`BM_FM_AW), .DW(`BM_FM_DW)) u_fm_buf0 (
        .clk   (clk),
        .we    (buf0_we),
        .waddr (buf0_waddr),
        .wdata (buf0_wdata),
        .re    (buf0_re),
        .raddr (tap_addr),
        .rdata (buf0_rdata)
    );

    dpram #(.DEPTH(`BM_FM_DEPTH), .AW(`BM_FM_AW), .DW(`BM_FM_DW)) u_fm_buf1 (
        .clk   (clk),
        .we    (buf1_we),
        .waddr (ofm_addr),
        .wdata (ofm_data),
        .re    (buf1_re),
        .raddr (tap_addr),
        .rdata (buf1_rdata)
    );

    // ------------------------------------------------------------------
    // ofm completion from the effective geometry
    function automatic logic [`BM_W_SIZE:0] eff_dim(
        input buffer_manager_pkg::size_t dim,
        input logic                      pool,
        input logic [1:0]                pool_stride,
        input logic                      up
    );
        if (pool) begin
            return (pool_stride == 2'd2) ? {1'b0, dim >> 1} : {1'b0, dim};
        end
        return up ? {dim, 1'b0} : {1'b0, dim};   // upsample only without pooling
    endfunction

    assign eff_w = eff_dim(width, maxpool, maxpool_stride, upsample);
    assign eff_h = eff_dim(height, maxpool, maxpool_stride, upsample);

    assign ofm_last_addr = buffer_manager_pkg::fm_addr_t'(eff_w * eff_h * channel_out - 1);
    assign ofm_sync_done = ofm_vld && (ofm_addr == ofm_last_addr);

endmodule

`default_nettype wire

// ==== design/dpram.sv ====
`timescale 1ns/10ps
`default_nettype none

module dpram #(
    parameter int DEPTH = 4096,
    parameter int AW    = 12,
    parameter int DW    = 32
) (
    input  wire           clk,
    input  wire           we,
    input  wire  [AW-1:0] waddr,
    input  wire  [DW-1:0] wdata,
    input  wire           re,
    input  wire  [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];    // holds between reads
        end
    end

endmodule

`default_nettype wire

// ==== design/buffer_manager_pkg.sv ====
`default_nettype none
`include "buffer_manager_cfg.svh"

package buffer_manager_pkg;

    typedef logic [`BM_FM_AW-1:0]     fm_addr_t;
    typedef logic [`BM_FM_DW-1:0]     fm_data_t;
    typedef logic [`BM_FILTER_AW-1:0] filter_addr_t;
    typedef logic [`BM_FILTER_DW-1:0] filter_word_t;
    typedef logic [`BM_W_SIZE-1:0]    size_t;
    typedef logic [`BM_W_CHANNEL-1:0] chan_t;
    typedef logic [3:0]               tap_idx_t;    // 0..8 kernel tap

    typedef enum logic {
        ROLE_IFM = 1'b0,
        ROLE_OFM = 1'b1
    } fm_role_e;

    typedef enum logic [1:0] {
        FL_IDLE    = 2'd0,
        FL_ARMED   = 2'd1,   // load edge seen, waiting for first beat
        FL_PACKING = 2'd2
    } filter_state_e;

endpackage

`default_nettype wire

// ==== design/buffer_manager_cfg.svh ====
`ifndef BUFFER_MANAGER_CFG_SVH
`define BUFFER_MANAGER_CFG_SVH

// feature-map ping-pong RAMs
`define BM_FM_DEPTH      4096
`define BM_FM_AW         12
`define BM_FM_DW         32     // also the axi data width

// filter banks, one byte lane of the axi word each
`define BM_FILTER_DEPTH  512
`define BM_FILTER_AW     9
`define BM_FILTER_DW     72     // 9 taps x 8 bit
`define BM_KERNEL_TAPS   9      // beats per filter word
`define BM_FILTER_BANKS  4

// layer geometry fields
`define BM_W_SIZE        8
`define BM_W_CHANNEL     8

`endif
